//--- design/axi_pkg.sv
package axi_pkg;

  // ========================================
  // widths and depths
  // ========================================

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_ID_W   = 1;
  localparam int AXI_LEN_W  = 8;   // AXI4 burst length field.
  localparam int AXI_SIZE_W = 3;

  localparam logic [AXI_SIZE_W-1:0] AXI_SIZE_4B = 3'b010;  // four bytes per beat.

  localparam int MEM_WORDS  = 256;
  localparam int MEM_AW     = $clog2(MEM_WORDS);
  localparam int MEM_LSB    = $clog2(AXI_STRB_W);  // byte offset bits inside a 64-bit word.

  // ========================================
  // opcodes
  // ========================================

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // ========================================
  // channel beats
  // ========================================

  // shared by the AW and AR channels.
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_LEN_W-1:0]  len;
    logic [AXI_SIZE_W-1:0] size;
    axi_burst_e            burst;
  } axi_ax_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    axi_resp_e           resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    axi_resp_e             resp;
    logic                  last;
  } axi_r_t;

  typedef struct packed {
    axi_ax_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    axi_ax_t ar;
    logic    ar_valid;
    logic    r_ready;
  } axi_req_t;

  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    axi_b_t b;
    logic   b_valid;
    logic   ar_ready;
    axi_r_t r;
    logic   r_valid;
  } axi_rsp_t;

endpackage

//--- design/core_pkg.sv
package core_pkg;

  localparam int CORE_DATA_W = 32;
  localparam int CORE_BE_W   = CORE_DATA_W / 8;  // one enable per byte lane.

  typedef logic [CORE_DATA_W-1:0] core_data_t;

  // held stable by the core from req until the grant cycle.
  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [CORE_BE_W-1:0] be;
    logic [31:0]          addr;
    core_data_t           wdata;
  } core_req_t;

  typedef struct packed {
    logic       gnt;
    logic       rvalid;
    core_data_t rdata;
  } core_rsp_t;

endpackage

//--- design/core2axi.sv
`timescale 1ns/100ps

module core2axi
  import axi_pkg::*;
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  core_req_t core_req_i,
  output core_rsp_t core_rsp_o,
  output axi_req_t  axi_req_o,
  input  axi_rsp_t  axi_rsp_i
);

  typedef enum logic [2:0] {
    IDLE,
    READ_WAIT,
    READ_ACK,
    WRITE_DATA,
    WRITE_WAIT
  } state_e;

  state_e                state_q;
  state_e                state_d;
  logic                  aw_valid;
  logic                  w_valid;
  logic                  b_ready;
  logic                  ar_valid;
  logic                  r_ready;
  logic                  gnt;
  logic                  done;
  logic                  rvalid_q;
  logic                  half_q;
  logic [AXI_ID_W-1:0]   id_q;
  axi_ax_t               ax;
  logic [AXI_STRB_W-1:0] strb;

  // ========================================
  // registers
  // ========================================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q  <= IDLE;
      rvalid_q <= 1'b0;
      id_q     <= '0;
    end
    else
    begin
      state_q  <= state_d;
      rvalid_q <= gnt && (state_q == READ_WAIT);  // read data follows a read grant.
      if (done)
        id_q <= ~id_q;  // a new ID for every completed access.
    end
  end

  always_ff @(posedge clk)
  begin
    half_q <= core_req_i.addr[2];  // the core still holds addr in the grant cycle.
  end

  // ========================================
  // control FSM
  // ========================================

  always_comb
  begin
    state_d  = state_q;
    done     = 1'b0;
    gnt      = 1'b0;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;

    case (state_q)
      IDLE:
      begin
        if (core_req_i.req)
        begin
          if (core_req_i.we)
          begin
            aw_valid = 1'b1;
            if (axi_rsp_i.aw_ready)
              state_d = WRITE_DATA;
          end
          else
          begin
            ar_valid = 1'b1;
            if (axi_rsp_i.ar_ready)
              state_d = READ_WAIT;
          end
        end
      end

      WRITE_DATA:
      begin
        w_valid = 1'b1;
        if (axi_rsp_i.w_ready)
        begin
          gnt     = 1'b1;  // the store leaves the core on the W transfer.
          state_d = WRITE_WAIT;
        end
      end

      WRITE_WAIT:
      begin
        b_ready = 1'b1;
        if (axi_rsp_i.b_valid)
        begin
          done    = 1'b1;
          state_d = IDLE;
        end
      end

      READ_WAIT:
      begin
        if (axi_rsp_i.r_valid)
        begin
          gnt     = 1'b1;
          state_d = READ_ACK;
        end
      end

      READ_ACK:
      begin
        r_ready = 1'b1;  // the slave holds R, so it is taken one cycle late.
        done    = 1'b1;
        state_d = IDLE;
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  // ========================================
  // AXI and core outputs
  // ========================================

  assign strb = core_req_i.addr[2] ? {core_req_i.be, {CORE_BE_W{1'b0}}}
                                   : {{CORE_BE_W{1'b0}}, core_req_i.be};

  always_comb
  begin
    ax.id    = id_q;
    ax.addr  = core_req_i.addr;
    ax.len   = '0;  // single beat.
    ax.size  = AXI_SIZE_4B;
    ax.burst = INCR;

    axi_req_o.aw       = ax;
    axi_req_o.aw_valid = aw_valid;
    axi_req_o.w.data   = {2{core_req_i.wdata}};  // both halves carry the word.
    axi_req_o.w.strb   = strb;
    axi_req_o.w.last   = 1'b1;
    axi_req_o.w_valid  = w_valid;
    axi_req_o.b_ready  = b_ready;
    axi_req_o.ar       = ax;
    axi_req_o.ar_valid = ar_valid;
    axi_req_o.r_ready  = r_ready;
  end

  always_comb
  begin
    core_rsp_o.gnt    = gnt;
    core_rsp_o.rvalid = rvalid_q;
    core_rsp_o.rdata  = half_q ? axi_rsp_i.r.data[AXI_DATA_W-1:CORE_DATA_W]
                               : axi_rsp_i.r.data[CORE_DATA_W-1:0];
  end

endmodule

//--- design/axi_sram_slave.sv
`timescale 1ns/100ps

module axi_sram_slave
  import axi_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  axi_req_t axi_req_i,
  output axi_rsp_t axi_rsp_o
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE_DATA,
    WRITE_RESP,
    READ_RESP
  } state_e;

  state_e                state_q;
  state_e                state_d;
  logic [AXI_DATA_W-1:0] mem [MEM_WORDS];
  logic [MEM_AW-1:0]     waddr_q;
  logic [AXI_DATA_W-1:0] rdata_q;
  logic [AXI_ID_W-1:0]   wid_q;
  logic [AXI_ID_W-1:0]   rid_q;
  logic                  aw_ready;
  logic                  ar_ready;
  logic                  w_ready;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  ar_fire;

  assign aw_ready = (state_q == IDLE);
  assign ar_ready = (state_q == IDLE) && !axi_req_i.aw_valid;  // AW wins a tie.
  assign w_ready  = (state_q == WRITE_DATA);

  assign aw_fire = axi_req_i.aw_valid && aw_ready;
  assign w_fire  = axi_req_i.w_valid && w_ready;
  assign ar_fire = axi_req_i.ar_valid && ar_ready;

  // ========================================
  // transaction FSM
  // ========================================

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (aw_fire)
          state_d = WRITE_DATA;
        else if (ar_fire)
          state_d = READ_RESP;
      end

      WRITE_DATA:
      begin
        if (w_fire)
          state_d = WRITE_RESP;
      end

      WRITE_RESP:
      begin
        if (axi_req_i.b_ready)
          state_d = IDLE;
      end

      READ_RESP:
      begin
        if (axi_req_i.r_ready)
          state_d = IDLE;
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      wid_q   <= '0;
      rid_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (aw_fire)
        wid_q <= axi_req_i.aw.id;  // echoed on B.
      if (ar_fire)
        rid_q <= axi_req_i.ar.id;
    end
  end

  // ========================================
  // memory
  // ========================================

  always_ff @(posedge clk)
  begin
    if (aw_fire)
      waddr_q <= axi_req_i.aw.addr[MEM_LSB +: MEM_AW];
    if (ar_fire)
      rdata_q <= mem[axi_req_i.ar.addr[MEM_LSB +: MEM_AW]];
    if (w_fire)
    begin
      for (int i = 0; i < AXI_STRB_W; i++)
      begin
        if (axi_req_i.w.strb[i])
          mem[waddr_q][i*8 +: 8] <= axi_req_i.w.data[i*8 +: 8];  // untouched lanes keep old bytes.
      end
    end
  end

  always_comb
  begin
    axi_rsp_o.aw_ready = aw_ready;
    axi_rsp_o.w_ready  = w_ready;
    axi_rsp_o.b.id     = wid_q;
    axi_rsp_o.b.resp   = OKAY;
    axi_rsp_o.b_valid  = (state_q == WRITE_RESP);
    axi_rsp_o.ar_ready = ar_ready;
    axi_rsp_o.r.id     = rid_q;
    axi_rsp_o.r.data   = rdata_q;
    axi_rsp_o.r.resp   = OKAY;
    axi_rsp_o.r.last   = 1'b1;
    axi_rsp_o.r_valid  = (state_q == READ_RESP);
  end

endmodule

//--- design/core_axi_top.sv
`timescale 1ns/100ps

module core_axi_top
  import axi_pkg::*;
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  core_req_t core_req_i,
  output core_rsp_t core_rsp_o
);

  axi_req_t axi_req;
  axi_rsp_t axi_rsp;

  core2axi u_core2axi (
    .clk        (clk),
    .rst_n      (rst_n),
    .core_req_i (core_req_i),
    .core_rsp_o (core_rsp_o),
    .axi_req_o  (axi_req),
    .axi_rsp_i  (axi_rsp)
  );

  axi_sram_slave u_sram (
    .clk       (clk),
    .rst_n     (rst_n),
    .axi_req_i (axi_req),
    .axi_rsp_o (axi_rsp)
  );

endmodule

//--- verif/core_axi_assert.sv
`timescale 1ns/100ps

module core_axi_assert
  import axi_pkg::*;
  import core_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input axi_req_t  axi_req_i,
  input axi_rsp_t  axi_rsp_i,
  input core_rsp_t core_rsp_i
);

  logic                aw_open;
  logic                ar_open;
  logic [AXI_ID_W-1:0] id_issued;
  int unsigned         fail_cnt = 0;  // number of failed assertions so far.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      aw_open   <= 1'b0;
      ar_open   <= 1'b0;
      id_issued <= '0;
    end
    else
    begin
      if (axi_req_i.aw_valid && axi_rsp_i.aw_ready)
      begin
        aw_open   <= 1'b1;
        id_issued <= axi_req_i.aw.id;
      end
      else if (axi_req_i.w_valid && axi_rsp_i.w_ready)
        aw_open <= 1'b0;
      if (axi_req_i.ar_valid && axi_rsp_i.ar_ready)
      begin
        ar_open   <= 1'b1;
        id_issued <= axi_req_i.ar.id;
      end
      else if (axi_rsp_i.r_valid && axi_req_i.r_ready)
        ar_open <= 1'b0;
    end
  end

  // ========================================
  // handshake rules
  // ========================================

  aw_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    axi_req_i.aw_valid && !axi_rsp_i.aw_ready |=> axi_req_i.aw_valid)
    else
    begin
      fail_cnt++;
      $error("aw_valid withdrawn before aw_ready");
    end

  w_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    axi_req_i.w_valid && !axi_rsp_i.w_ready |=> axi_req_i.w_valid)
    else
    begin
      fail_cnt++;
      $error("w_valid withdrawn before w_ready");
    end

  ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    axi_req_i.ar_valid && !axi_rsp_i.ar_ready |=> axi_req_i.ar_valid)
    else
    begin
      fail_cnt++;
      $error("ar_valid withdrawn before ar_ready");
    end

  b_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    axi_rsp_i.b_valid && !axi_req_i.b_ready |=> axi_rsp_i.b_valid)
    else
    begin
      fail_cnt++;
      $error("b_valid withdrawn before b_ready");
    end

  r_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    axi_rsp_i.r_valid && !axi_req_i.r_ready |=> axi_rsp_i.r_valid)
    else
    begin
      fail_cnt++;
      $error("r_valid withdrawn before r_ready");
    end

  w_after_aw_a: assert property (@(posedge clk) disable iff (!rst_n)
    axi_req_i.w_valid |-> aw_open)
    else
    begin
      fail_cnt++;
      $error("w_valid raised without an accepted aw");
    end

  b_id_a: assert property (@(posedge clk) disable iff (!rst_n)
    axi_rsp_i.b_valid |-> axi_rsp_i.b.id == id_issued)
    else
    begin
      fail_cnt++;
      $error("b.id differs from the issued ID");
    end

  r_id_a: assert property (@(posedge clk) disable iff (!rst_n)
    axi_rsp_i.r_valid |-> axi_rsp_i.r.id == id_issued)
    else
    begin
      fail_cnt++;
      $error("r.id differs from the issued ID");
    end

  // a grant needs an open AXI transaction on the bus.
  gnt_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    core_rsp_i.gnt |-> (aw_open && axi_req_i.w_valid && axi_rsp_i.w_ready)
                    || (ar_open && axi_rsp_i.r_valid))
    else
    begin
      fail_cnt++;
      $error("gnt while the bridge is idle");
    end

endmodule

bind core2axi core_axi_assert u_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .axi_req_i  (axi_req_o),
  .axi_rsp_i  (axi_rsp_i),
  .core_rsp_i (core_rsp_o)
);

//--- verif/core_axi_tb.sv
`timescale 1ns/100ps

module core_axi_tb
  import core_pkg::*;
();

  typedef struct packed {
    logic                 we;
    logic [31:0]          addr;
    logic [CORE_BE_W-1:0] be;
    core_data_t           wdata;
    core_data_t           rdata;  // expected value, used by reads only.
  } entry_t;

  logic        clk;
  logic        rst_n;
  core_req_t   core_req_i;
  core_rsp_t   core_rsp_o;
  entry_t      table_q [$];
  logic [31:0] written_q [$];
  core_data_t  shadow [512];
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  bit          verdict_done = 1'b0;

  core_axi_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .core_req_i (core_req_i),
    .core_rsp_o (core_rsp_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ========================================
  // compare tasks
  // ========================================

  task automatic check_rdata(input core_data_t act, input core_data_t exp);
    if (act !== exp)
    begin
      verdict_done = 1'b1;
      $display("** Error at %0t: rdata expected %08h, got %08h", $time, exp, act);
      $display("TEST FAILED");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic check_resp(input core_rsp_t act, input core_rsp_t exp);
    if (act.gnt !== exp.gnt || act.rvalid !== exp.rvalid)
    begin
      verdict_done = 1'b1;
      $display("** Error at %0t: gnt/rvalid expected %b/%b, got %b/%b",
               $time, exp.gnt, exp.rvalid, act.gnt, act.rvalid);
      $display("TEST FAILED");
      $fatal(1, "response timing mismatch");
    end
  endtask

  task automatic check_timeout();
    if (cycle_cnt >= cycle_limit)
    begin
      verdict_done = 1'b1;
      $display("timeout after %0d cycles, the request sequence did not finish", cycle_cnt);
      $display("TEST FAILED");
      $fatal(1, "simulation timeout");
    end
  endtask

  task automatic poll_checker();
    if (dut_i.u_core2axi.u_assert.fail_cnt != 0)
    begin
      verdict_done = 1'b1;
      $display("a protocol assertion in the bound AXI checker failed by %0t", $time);
      $display("TEST FAILED");
      $fatal(1, "assertion failure");
    end
  endtask

  // ========================================
  // stimulus table
  // ========================================

  task automatic add_entry(input logic we, input logic [31:0] addr,
                           input logic [CORE_BE_W-1:0] be, input core_data_t wdata);
    entry_t     e;
    logic [8:0] widx;
    widx    = addr[10:2];  // one shadow slot per 32-bit word.
    e.we    = we;
    e.addr  = addr;
    e.be    = be;
    e.wdata = wdata;
    e.rdata = shadow[widx];
    if (we)
    begin
      for (int b = 0; b < CORE_BE_W; b++)
      begin
        if (be[b])
          shadow[widx][b*8 +: 8] = wdata[b*8 +: 8];
      end
      written_q.push_back(addr);
    end
    table_q.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] addr;
    logic        we;
    foreach (shadow[i])
      shadow[i] = '0;
    // neighbors around the 64-bit word at 0x100.
    add_entry(1'b1, 32'h0000_00f8, 4'hf, 32'h1111_0000);
    add_entry(1'b1, 32'h0000_00fc, 4'hf, 32'h2222_0001);
    add_entry(1'b1, 32'h0000_0108, 4'hf, 32'h3333_0002);
    add_entry(1'b1, 32'h0000_010c, 4'hf, 32'h4444_0003);
    add_entry(1'b1, 32'h0000_0100, 4'hf, 32'hdead_beef);  // lower half.
    add_entry(1'b0, 32'h0000_0100, 4'h0, 32'h0);
    add_entry(1'b1, 32'h0000_0104, 4'hf, 32'hcafe_f00d);  // upper half.
    add_entry(1'b0, 32'h0000_0104, 4'h0, 32'h0);
    add_entry(1'b0, 32'h0000_0100, 4'h0, 32'h0);
    add_entry(1'b1, 32'h0000_0100, 4'b0011, 32'h5566_7788);
    add_entry(1'b0, 32'h0000_0100, 4'h0, 32'h0);
    add_entry(1'b1, 32'h0000_0104, 4'b1000, 32'h99aa_bbcc);
    add_entry(1'b0, 32'h0000_0104, 4'h0, 32'h0);
    add_entry(1'b1, 32'h0000_0104, 4'b0101, 32'h0102_0304);
    add_entry(1'b0, 32'h0000_0104, 4'h0, 32'h0);
    add_entry(1'b0, 32'h0000_0100, 4'h0, 32'h0);
    add_entry(1'b0, 32'h0000_00f8, 4'h0, 32'h0);
    add_entry(1'b0, 32'h0000_00fc, 4'h0, 32'h0);
    add_entry(1'b0, 32'h0000_0108, 4'h0, 32'h0);
    add_entry(1'b0, 32'h0000_010c, 4'h0, 32'h0);
    add_entry(1'b1, 32'h0000_07f8, 4'hf, 32'h0bad_c0de);  // last word of the memory.
    add_entry(1'b1, 32'h0000_07fc, 4'hf, 32'h1234_5678);
    add_entry(1'b0, 32'h0000_07f8, 4'h0, 32'h0);
    add_entry(1'b0, 32'h0000_07fc, 4'h0, 32'h0);
    repeat (32)
    begin
      addr = written_q[$urandom_range(written_q.size() - 1)];
      we   = ($urandom_range(1) == 1);
      if (we)
        add_entry(1'b1, addr, 4'($urandom_range(15, 1)), $urandom());
      else
        add_entry(1'b0, addr, 4'h0, 32'h0);
    end
  endtask

  task automatic drive_entry(input entry_t e);
    core_req_t r;
    r.req   = 1'b1;
    r.we    = e.we;
    r.be    = e.be;
    r.addr  = e.addr;
    r.wdata = e.wdata;
    core_req_i <= r;
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial
  begin
    entry_t     cur;
    core_rsp_t  exp_rsp;
    core_data_t rv_data;
    int         idx;
    int         c;
    int         gnt_cyc;
    int         rv_cyc;
    int         stop_cyc;

    $timeformat(-9, 1, " ns", 0);
    void'($urandom(32'hac46_68e0));
    rst_n      = 1'b0;
    core_req_i = '0;
    rv_data    = '0;
    build_table();
    cycle_limit = table_q.size() * 3 + 50;

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    repeat (3)
    begin
      @(negedge clk);
      check_resp(core_rsp_o, '0);  // quiet until the first request.
    end

    idx      = 0;
    rv_cyc   = -1;
    stop_cyc = -1;
    @(posedge clk);
    cur = table_q[0];
    drive_entry(cur);
    @(negedge clk);
    gnt_cyc = cycle_cnt + 1;  // the bridge is idle, so gnt follows one cycle later.

    while (stop_cyc < 0 || cycle_cnt <= stop_cyc)
    begin
      c = cycle_cnt;
      check_timeout();
      poll_checker();
      exp_rsp        = '0;
      exp_rsp.gnt    = (c == gnt_cyc);
      exp_rsp.rvalid = (c == rv_cyc);
      check_resp(core_rsp_o, exp_rsp);
      if (exp_rsp.rvalid)
        check_rdata(core_rsp_o.rdata, rv_data);
      @(posedge clk);
      if (exp_rsp.gnt)
      begin
        if (!cur.we)
        begin
          rv_cyc  = c + 1;
          rv_data = cur.rdata;
        end
        idx++;
        if (idx < table_q.size())
        begin
          cur = table_q[idx];
          drive_entry(cur);
          gnt_cyc = c + 3;  // seen at gnt+1, bridge idle at gnt+2.
        end
        else
        begin
          core_req_i <= '0;
          stop_cyc = c + 4;
        end
      end
      @(negedge clk);
    end

    if (dut_i.u_core2axi.u_assert.fail_cnt != 0)
      poll_checker();
    else
    begin
      verdict_done = 1'b1;
      $display("TEST OK");
      $finish;
    end
  end

  final
  begin
    if (!verdict_done)
      $display("TEST FAILED");
  end

endmodule

//--- core_axi_sub.f
design/axi_pkg.sv
design/core_pkg.sv
design/core2axi.sv
design/axi_sram_slave.sv
design/core_axi_top.sv
verif/core_axi_assert.sv
verif/core_axi_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = core_axi_tb
FILELIST = core_axi_sub.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
